//--- hdl/rob_pkg.sv
/*
 * Shared constants and enums for the register-readiness scoreboard.
 * Modules refer to these by scoped name and take their widths from parameters.
 */

package rob_pkg;

	// ==============================
	// Reorder buffer sizing
	// ==============================

	// Width of a reorder slot index
	localparam int rob_id_w = 3;

	// Number of reorder slots, which must be a power of two
	localparam int rob_entries = 8;

	// ==============================
	// Architectural registers
	// ==============================

	// Number of architectural registers, with register 0 hardwired valid
	localparam int reg_count = 32;

	// Width of a register index
	localparam int reg_idx_w = 5;

	// ==============================
	// Enumerations
	// ==============================

	// Life cycle of a reorder slot from allocation to retirement
	typedef enum logic [1:0] {
		slot_free   = 2'd0,
		slot_issued = 2'd1,
		slot_done   = 2'd2
	} slot_state_e;

	// How many slots leave the head of the buffer in one cycle
	typedef enum logic [1:0] {
		commit_none = 2'd0,
		commit_one  = 2'd1,
		commit_two  = 2'd2
	} commit_sel_e;

endpackage

//--- hdl/reorder_buffer.sv
/*
 * Circular reorder buffer that hands out slots at decode, marks them done on completion,
 * retires up to two in order per cycle and squashes younger slots on a branch miss.
 */
`timescale 1ns/1ps

module reorder_buffer #(
	parameter int rob_entries = rob_pkg::rob_entries,
	parameter int reg_count = rob_pkg::reg_count,
	localparam int id_w = $clog2(rob_entries),
	localparam int idx_w = $clog2(reg_count)
) (
	input  logic clk,
	input  logic rst,
	input  logic dec_req,
	input  logic dec0_en,
	input  logic dec0_wr,
	input  logic [idx_w-1:0] dec0_tgt,
	input  logic dec1_en,
	input  logic dec1_wr,
	input  logic [idx_w-1:0] dec1_tgt,
	input  logic cmp_valid,
	input  logic [id_w-1:0] cmp_id,
	input  logic br_miss,
	input  logic [id_w-1:0] br_id,
	output logic dec_ack,
	output logic [id_w-1:0] dec0_id,
	output logic [id_w-1:0] dec1_id,
	output logic alloc0_fire,
	output logic alloc1_fire,
	output logic commit0_valid,
	output logic [id_w-1:0] commit0_id,
	output logic commit0_wr,
	output logic [idx_w-1:0] commit0_tgt,
	output logic commit1_valid,
	output logic [id_w-1:0] commit1_id,
	output logic commit1_wr,
	output logic [idx_w-1:0] commit1_tgt,
	output logic br_miss_fire,
	output logic [reg_count-1:0] live_target,
	output logic [rob_entries-1:0] ent_live,
	output logic [rob_entries-1:0] ent_wr,
	output logic [rob_entries-1:0][idx_w-1:0] ent_tgt,
	output logic [id_w-1:0] head_id
);

	logic [id_w-1:0] head;
	logic [id_w-1:0] tail;
	logic [id_w:0] count;
	rob_pkg::slot_state_e slot_state [rob_entries];
	logic [rob_entries-1:0] slot_wr;
	logic [rob_entries-1:0][idx_w-1:0] slot_tgt;
	logic [id_w-1:0] dec0_id_q;
	logic [id_w-1:0] dec1_id_q;
	logic [id_w:0] need;
	logic [id_w:0] free_slots;
	logic [id_w:0] n_alloc;
	logic alloc_ok;
	logic [id_w-1:0] head_p1;
	rob_pkg::commit_sel_e commit_sel;
	logic [1:0] n_commit;
	logic [rob_entries-1:0] committing;
	logic [rob_entries-1:0] keep;
	logic [id_w-1:0] br_span;
	logic [id_w-1:0] slot_off;
	logic [id_w:0] survivors;

	// ==============================
	// Decode side allocation
	// ==============================

	// Allocation needs a slot for every enabled instruction and waits out a flush
	always_comb begin
		need = (id_w+1)'(dec0_en) + (id_w+1)'(dec1_en);
		free_slots = (id_w+1)'(rob_entries) - count;
		alloc_ok = dec_req && !dec_ack && !br_miss_fire && (free_slots >= need);
		alloc0_fire = alloc_ok && dec0_en;
		alloc1_fire = alloc_ok && dec1_en;
		n_alloc = alloc_ok ? need : '0;
	end

	// Before the acknowledge the ids show the slots that would be taken
	// Once acknowledged they hold the slots that were actually allocated
	assign dec0_id = dec_ack ? dec0_id_q : tail;
	assign dec1_id = dec_ack ? dec1_id_q : (dec0_en ? tail + 1'b1 : tail);

	// A miss only counts when its branch still occupies a slot
	assign br_miss_fire = br_miss && (slot_state[br_id] != rob_pkg::slot_free);

	// ==============================
	// Commit selection
	// ==============================

	// Retire the head when done, and the next slot too if it is done as well
	always_comb begin
		head_p1 = head + 1'b1;
		commit_sel = rob_pkg::commit_none;
		if (slot_state[head] == rob_pkg::slot_done) begin
			if (slot_state[head_p1] == rob_pkg::slot_done)
				commit_sel = rob_pkg::commit_two;
			else
				commit_sel = rob_pkg::commit_one;
		end
		committing = '0;
		n_commit = 2'd0;
		case (commit_sel)
			rob_pkg::commit_one: begin
				committing[head] = 1'b1;
				n_commit = 2'd1;
			end
			rob_pkg::commit_two: begin
				committing[head] = 1'b1;
				committing[head_p1] = 1'b1;
				n_commit = 2'd2;
			end
			default: n_commit = 2'd0;
		endcase
	end

	// ==============================
	// Flush and survivor tracking
	// ==============================

	// A slot survives a miss if it lies between the head and the branch inclusive
	// Slots retiring in the same cycle are removed first, so they never count as live
	always_comb begin
		br_span = br_id - head;
		survivors = {1'b0, br_span} + 1'b1;
		live_target = '0;
		for (int i = 0; i < rob_entries; i++) begin
			slot_off = id_w'(i) - head;
			keep[i] = (slot_state[i] != rob_pkg::slot_free) && (slot_off <= br_span);
			if (br_miss_fire)
				ent_live[i] = keep[i] && !committing[i];
			else
				ent_live[i] = (slot_state[i] != rob_pkg::slot_free) && !committing[i];
			if (ent_live[i] && slot_wr[i])
				live_target[slot_tgt[i]] = 1'b1;
		end
	end

	assign ent_wr = slot_wr;
	assign ent_tgt = slot_tgt;
	assign head_id = head;

	// ==============================
	// Control state
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			dec_ack <= 1'b0;
			commit0_valid <= 1'b0;
			commit1_valid <= 1'b0;
			for (int i = 0; i < rob_entries; i++)
				slot_state[i] <= rob_pkg::slot_free;
		end
		else begin
			// Four-phase acknowledge rises on allocation and drops once the request is gone
			if (alloc_ok)
				dec_ack <= 1'b1;
			else if (!dec_req)
				dec_ack <= 1'b0;

			head <= head + id_w'(n_commit);
			if (br_miss_fire) begin
				// Retirement is taken out of the survivors before the tail is pulled back
				tail <= br_id + 1'b1;
				count <= survivors - (id_w+1)'(n_commit);
			end
			else begin
				tail <= tail + id_w'(n_alloc);
				count <= count + n_alloc - (id_w+1)'(n_commit);
			end

			for (int i = 0; i < rob_entries; i++) begin
				if (committing[i])
					slot_state[i] <= rob_pkg::slot_free;
				else if (br_miss_fire && !keep[i])
					slot_state[i] <= rob_pkg::slot_free;
				else if (cmp_valid && cmp_id == id_w'(i) &&
						slot_state[i] == rob_pkg::slot_issued)
					slot_state[i] <= rob_pkg::slot_done;
			end
			// Allocated slots were free, so these never collide with the loop above
			if (alloc0_fire)
				slot_state[tail] <= rob_pkg::slot_issued;
			if (alloc1_fire)
				slot_state[dec1_id] <= rob_pkg::slot_issued;

			commit0_valid <= (commit_sel != rob_pkg::commit_none);
			commit1_valid <= (commit_sel == rob_pkg::commit_two);
		end
	end

	// Slot payload is captured at allocation and the commit details track the head each cycle
	always_ff @(posedge clk) begin
		if (alloc0_fire) begin
			slot_wr[tail] <= dec0_wr;
			slot_tgt[tail] <= dec0_tgt;
		end
		if (alloc1_fire) begin
			slot_wr[dec1_id] <= dec1_wr;
			slot_tgt[dec1_id] <= dec1_tgt;
		end
		if (alloc_ok) begin
			dec0_id_q <= dec0_id;
			dec1_id_q <= dec1_id;
		end
		commit0_id <= head;
		commit0_wr <= slot_wr[head];
		commit0_tgt <= slot_tgt[head];
		commit1_id <= head_p1;
		commit1_wr <= slot_wr[head_p1];
		commit1_tgt <= slot_tgt[head_p1];
	end

endmodule

//--- hdl/reg_source_table.sv
/*
 * Register source table holding the newest producing slot for every register.
 * Decode writes it, and a branch miss rebuilds it from the surviving slots.
 */
`timescale 1ns/1ps

module reg_source_table #(
	parameter int rob_entries = rob_pkg::rob_entries,
	parameter int reg_count = rob_pkg::reg_count,
	localparam int id_w = $clog2(rob_entries),
	localparam int idx_w = $clog2(reg_count)
) (
	input  logic clk,
	input  logic rst,
	input  logic alloc0_fire,
	input  logic alloc1_fire,
	input  logic dec0_wr,
	input  logic [idx_w-1:0] dec0_tgt,
	input  logic dec1_wr,
	input  logic [idx_w-1:0] dec1_tgt,
	input  logic [id_w-1:0] dec0_id,
	input  logic [id_w-1:0] dec1_id,
	input  logic br_miss_fire,
	input  logic [rob_entries-1:0] ent_live,
	input  logic [rob_entries-1:0] ent_wr,
	input  logic [rob_entries-1:0][idx_w-1:0] ent_tgt,
	input  logic [id_w-1:0] head_id,
	output logic [reg_count-1:0][id_w-1:0] reg_src
);

	logic [reg_count-1:0][id_w-1:0] rebuilt;
	logic [id_w-1:0] scan_id;

	// ==============================
	// Rebuild after a flush
	// ==============================

	// Walk from oldest to youngest so the last live writer of a register wins
	// Registers with no survivor keep their old entry since they go valid anyway
	always_comb begin
		rebuilt = reg_src;
		for (int k = 0; k < rob_entries; k++) begin
			scan_id = head_id + id_w'(k);
			if (ent_live[scan_id] && ent_wr[scan_id])
				rebuilt[ent_tgt[scan_id]] = scan_id;
		end
	end

	// ==============================
	// Table update
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			reg_src <= '0;
		end
		else if (br_miss_fire) begin
			reg_src <= rebuilt;
		end
		else begin
			if (alloc0_fire && dec0_wr)
				reg_src[dec0_tgt] <= dec0_id;
			// Slot 1 is younger, so it overrides slot 0 on a shared target
			if (alloc1_fire && dec1_wr)
				reg_src[dec1_tgt] <= dec1_id;
		end
	end

endmodule

//--- hdl/regfile_valid.sv
/*
 * Per-register valid bits for operand readiness.
 * Decode clears a destination, and commit or a branch miss makes it valid again.
 */
`timescale 1ns/1ps

module regfile_valid #(
	parameter int rob_entries = rob_pkg::rob_entries,
	parameter int reg_count = rob_pkg::reg_count,
	localparam int id_w = $clog2(rob_entries),
	localparam int idx_w = $clog2(reg_count)
) (
	input  logic clk,
	input  logic rst,
	// Decode side allocation
	input  logic alloc0_fire,
	input  logic alloc1_fire,
	input  logic dec0_wr,
	input  logic [idx_w-1:0] dec0_tgt,
	input  logic dec1_wr,
	input  logic [idx_w-1:0] dec1_tgt,
	// Retirement pulses from the reorder buffer
	input  logic commit0_valid,
	input  logic commit0_wr,
	input  logic [id_w-1:0] commit0_id,
	input  logic [idx_w-1:0] commit0_tgt,
	input  logic commit1_valid,
	input  logic commit1_wr,
	input  logic [id_w-1:0] commit1_id,
	input  logic [idx_w-1:0] commit1_tgt,
	// Flush and producer tracking
	input  logic br_miss_fire,
	input  logic [reg_count-1:0] live_target,
	input  logic [reg_count-1:0][id_w-1:0] reg_src,
	output logic [reg_count-1:0] regfile_valid
);

	logic [reg_count-1:0] next_valid;
	logic commit0_match;
	logic commit1_match;

	// ==============================
	// Commit matching
	// ==============================

	// A commit only restores its register when it is still the newest producer
	// An older writer retiring leaves the bit low for the younger one
	assign commit0_match = commit0_valid && commit0_wr && (reg_src[commit0_tgt] == commit0_id);
	assign commit1_match = commit1_valid && commit1_wr && (reg_src[commit1_tgt] == commit1_id);

	// ==============================
	// Next state
	// ==============================

	always_comb begin
		next_valid = regfile_valid;

		// On a miss every register nobody left in flight will write is ready
		if (br_miss_fire) begin
			for (int n = 0; n < reg_count; n++) begin
				if (!live_target[n])
					next_valid[n] = 1'b1;
			end
		end

		if (commit0_match)
			next_valid[commit0_tgt] = 1'b1;
		if (commit1_match)
			next_valid[commit1_tgt] = 1'b1;

		// A new writer takes precedence over any restore in the same cycle
		if (alloc0_fire && dec0_wr)
			next_valid[dec0_tgt] = 1'b0;
		if (alloc1_fire && dec1_wr)
			next_valid[dec1_tgt] = 1'b0;

		// Register 0 reads as a constant and is never waited on
		next_valid[0] = 1'b1;
	end

	// ==============================
	// Valid register
	// ==============================

	// Everything is ready out of reset since nothing is in flight
	always_ff @(posedge clk) begin
		if (rst)
			regfile_valid <= '1;
		else
			regfile_valid <= next_valid;
	end

endmodule

//--- hdl/scoreboard_top.sv
/*
 * Top level of the register-readiness scoreboard.
 * Connects the reorder buffer, the source table and the valid bits and sets their sizes.
 */
`timescale 1ns/1ps

module scoreboard_top #(
	parameter int rob_entries = rob_pkg::rob_entries,
	parameter int reg_count = rob_pkg::reg_count,
	localparam int id_w = $clog2(rob_entries),
	localparam int idx_w = $clog2(reg_count)
) (
	input  logic clk,
	input  logic rst,
	// Decode port with four-phase handshake
	input  logic dec_req,
	input  logic dec0_en,
	input  logic dec0_wr,
	input  logic [idx_w-1:0] dec0_tgt,
	input  logic dec1_en,
	input  logic dec1_wr,
	input  logic [idx_w-1:0] dec1_tgt,
	output logic dec_ack,
	output logic [id_w-1:0] dec0_id,
	output logic [id_w-1:0] dec1_id,
	// Completion and branch miss pulses
	input  logic cmp_valid,
	input  logic [id_w-1:0] cmp_id,
	input  logic br_miss,
	input  logic [id_w-1:0] br_id,
	// Retirement pulses
	output logic commit0_valid,
	output logic [id_w-1:0] commit0_id,
	output logic commit0_wr,
	output logic [idx_w-1:0] commit0_tgt,
	output logic commit1_valid,
	output logic [id_w-1:0] commit1_id,
	output logic commit1_wr,
	output logic [idx_w-1:0] commit1_tgt,
	output logic [reg_count-1:0] regfile_valid
);

	logic alloc0_fire;
	logic alloc1_fire;
	logic br_miss_fire;
	logic [reg_count-1:0] live_target;
	logic [rob_entries-1:0] ent_live;
	logic [rob_entries-1:0] ent_wr;
	logic [rob_entries-1:0][idx_w-1:0] ent_tgt;
	logic [id_w-1:0] head_id;
	logic [reg_count-1:0][id_w-1:0] reg_src;

	// ==============================
	// Slot tracking
	// ==============================

	reorder_buffer #(.rob_entries(rob_entries), .reg_count(reg_count)) reorder_buffer_i (
		.clk, .rst, .dec_req,
		.dec0_en, .dec0_wr, .dec0_tgt, .dec1_en, .dec1_wr, .dec1_tgt,
		.cmp_valid, .cmp_id, .br_miss, .br_id,
		.dec_ack, .dec0_id, .dec1_id, .alloc0_fire, .alloc1_fire,
		.commit0_valid, .commit0_id, .commit0_wr, .commit0_tgt,
		.commit1_valid, .commit1_id, .commit1_wr, .commit1_tgt,
		.br_miss_fire, .live_target, .ent_live, .ent_wr, .ent_tgt, .head_id
	);

	// ==============================
	// Producer table and valid bits
	// ==============================

	reg_source_table #(.rob_entries(rob_entries), .reg_count(reg_count)) reg_source_table_i (
		.clk, .rst, .alloc0_fire, .alloc1_fire,
		.dec0_wr, .dec0_tgt, .dec1_wr, .dec1_tgt, .dec0_id, .dec1_id,
		.br_miss_fire, .ent_live, .ent_wr, .ent_tgt, .head_id, .reg_src
	);

	regfile_valid #(.rob_entries(rob_entries), .reg_count(reg_count)) regfile_valid_i (
		.clk, .rst, .alloc0_fire, .alloc1_fire,
		.dec0_wr, .dec0_tgt, .dec1_wr, .dec1_tgt,
		.commit0_valid, .commit0_wr, .commit0_id, .commit0_tgt,
		.commit1_valid, .commit1_wr, .commit1_id, .commit1_tgt,
		.br_miss_fire, .live_target, .reg_src, .regfile_valid
	);

endmodule

//--- verification/tb_scoreboard_top.sv
/*
 * Testbench for the scoreboard top level with a transaction model of slots,
 * producers and register valid bits. Run it as the simulation top module.
 */
`timescale 1ns/1ps

module tb_scoreboard_top;

	localparam int id_w = rob_pkg::rob_id_w;
	localparam int idx_w = rob_pkg::reg_idx_w;
	localparam int nregs = rob_pkg::reg_count;
	localparam int slots = rob_pkg::rob_entries;
	localparam int limit = 200;

	logic clk = 1'b0;
	logic rst;
	logic dec_req, dec0_en, dec0_wr, dec1_en, dec1_wr, cmp_valid, br_miss;
	logic [idx_w-1:0] dec0_tgt, dec1_tgt;
	logic [id_w-1:0] cmp_id, br_id;
	logic dec_ack, commit0_valid, commit0_wr, commit1_valid, commit1_wr;
	logic [id_w-1:0] dec0_id, dec1_id, commit0_id, commit1_id;
	logic [idx_w-1:0] commit0_tgt, commit1_tgt;
	logic [nregs-1:0] regfile_valid;

	// Model of the slots in flight, oldest first, and of the register state
	logic [id_w-1:0] q_id [$];
	logic m_wr [slots];
	logic [idx_w-1:0] m_tgt [slots];
	logic m_done [slots];
	logic [id_w-1:0] m_src [nregs];
	logic [nregs-1:0] m_valid;
	logic [id_w-1:0] m_tail;
	logic [id_w-1:0] oldest, second;
	integer seed;

	always #5 clk = ~clk;

	scoreboard_top #(.rob_entries(slots), .reg_count(nregs)) scoreboard_top_i (.*);

	// ==============================
	// Checking helpers
	// ==============================

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		assert (actual === expected) else
			fail_now($sformatf("Error at time %0t: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual));
	endtask

	// Decode handshake stays in four-phase order
	assert property (@(posedge clk) disable iff (rst) $rose(dec_ack) |-> $past(dec_req))
		else fail_now("dec_ack rose while dec_req was low");
	assert property (@(posedge clk) disable iff (rst) $fell(dec_ack) |-> !$past(dec_req))
		else fail_now("dec_ack fell while dec_req was still high");
	assert property (@(posedge clk) disable iff (rst) regfile_valid[0])
		else fail_now("Register 0 lost its valid bit");
	// The second commit port only ever carries the slot right after the first
	assert property (@(posedge clk) disable iff (rst)
			commit1_valid |-> commit0_valid && commit1_id == commit0_id + 1'b1)
		else fail_now("commit1 fired without a consecutive commit0");

	// Each commit must be the oldest slot in flight, and it must have completed
	task automatic retire(input string port, input logic [id_w-1:0] id, input logic wr,
			input logic [idx_w-1:0] tgt);
		logic [id_w-1:0] exp_id;
		if (q_id.size() == 0)
			fail_now($sformatf("A %s pulse came with no slot in flight", port));
		exp_id = q_id.pop_front();
		check_eq({port, "_id"}, exp_id, id);
		check_eq({port, "_wr"}, m_wr[exp_id], wr);
		check_eq({port, "_tgt"}, m_tgt[exp_id], tgt);
		if (!m_done[exp_id])
			fail_now($sformatf("Slot %0d committed before it completed", exp_id));
		// Only the newest producer of a register makes it valid again
		if (m_wr[exp_id] && m_src[m_tgt[exp_id]] == exp_id)
			m_valid[m_tgt[exp_id]] = 1'b1;
	endtask

	always @(negedge clk) begin
		if (rst === 1'b0) begin
			if (commit0_valid === 1'b1)
				retire("commit0", commit0_id, commit0_wr, commit0_tgt);
			if (commit1_valid === 1'b1)
				retire("commit1", commit1_id, commit1_wr, commit1_tgt);
		end
	end

	// ==============================
	// Stimulus tasks
	// ==============================

	task automatic allocate(input logic [id_w-1:0] id, input logic wr,
			input logic [idx_w-1:0] tgt);
		q_id.push_back(id);
		m_wr[id] = wr;
		m_tgt[id] = tgt;
		m_done[id] = 1'b0;
		if (wr) begin
			m_src[tgt] = id;
			m_valid[tgt] = (tgt == '0);
		end
	endtask

	// Full four-phase transfer, returning once dec_ack is low again
	task automatic decode(input logic en0, input logic wr0, input logic [idx_w-1:0] t0,
			input logic en1, input logic wr1, input logic [idx_w-1:0] t1);
		int n;
		logic [id_w-1:0] id;
		dec0_en = en0;
		dec0_wr = wr0;
		dec0_tgt = t0;
		dec1_en = en1;
		dec1_wr = wr1;
		dec1_tgt = t1;
		dec_req = 1'b1;
		n = 0;
		while (dec_ack !== 1'b1) begin
			if (n == limit)
				fail_now("Timeout while waiting for dec_ack to rise");
			@(negedge clk);
			n++;
		end
		// The acknowledge may only come once there is room for every enabled slot
		if (q_id.size() + en0 + en1 > slots)
			fail_now("dec_ack rose while the reorder buffer had too few free slots");
		// Slots are handed out in order from the tail, so slot 1 is the younger one
		id = m_tail;
		if (en0) begin
			check_eq("dec0_id", id, dec0_id);
			allocate(id, wr0, t0);
			id = id + 1'b1;
		end
		if (en1) begin
			check_eq("dec1_id", id, dec1_id);
			allocate(id, wr1, t1);
			id = id + 1'b1;
		end
		m_tail = id;
		check_eq("regfile_valid", m_valid, regfile_valid);
		dec_req = 1'b0;
		n = 0;
		while (dec_ack !== 1'b0) begin
			if (n == limit)
				fail_now("Timeout while waiting for dec_ack to fall");
			@(negedge clk);
			n++;
		end
	endtask

	task automatic complete(input logic [id_w-1:0] id);
		cmp_valid = 1'b1;
		cmp_id = id;
		m_done[id] = 1'b1;
		@(negedge clk);
		cmp_valid = 1'b0;
	endtask

	// Completes every slot in flight except the youngest few, in random order
	task automatic complete_random(input int keep);
		logic [id_w-1:0] pend [$];
		int idx;
		for (int i = 0; i < q_id.size() - keep; i++)
			pend.push_back(q_id[i]);
		while (pend.size() > 0) begin
			idx = $unsigned($random(seed)) % pend.size();
			complete(pend[idx]);
			pend.delete(idx);
		end
	endtask

	task automatic drain_to(input int left);
		int n;
		n = 0;
		while (q_id.size() != left) begin
			if (n == limit)
				fail_now("Timeout while waiting for commits to drain");
			@(negedge clk);
			n++;
		end
		// The last commit pulse reaches the valid bits at the next edge
		@(negedge clk);
		check_eq("regfile_valid", m_valid, regfile_valid);
	endtask

	// Drops the slots younger than the branch and rebuilds producers from survivors
	task automatic branch_miss(input logic [id_w-1:0] id);
		int pos;
		logic [nregs-1:0] live;
		pos = -1;
		foreach (q_id[i])
			if (q_id[i] == id)
				pos = i;
		if (pos < 0)
			fail_now("Branch miss names a slot that is not in flight");
		while (q_id.size() > pos + 1)
			q_id.delete(q_id.size() - 1);
		m_tail = id + 1'b1;
		live = '0;
		foreach (q_id[i]) begin
			if (m_wr[q_id[i]]) begin
				live[m_tgt[q_id[i]]] = 1'b1;
				m_src[m_tgt[q_id[i]]] = q_id[i];
			end
		end
		m_valid = m_valid | ~live;
		br_miss = 1'b1;
		br_id = id;
		@(negedge clk);
		br_miss = 1'b0;
		check_eq("regfile_valid", m_valid, regfile_valid);
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		seed = 13464;
		rst = 1'b1;
		dec_req = 1'b0;
		dec0_en = 1'b0;
		dec0_wr = 1'b0;
		dec0_tgt = '0;
		dec1_en = 1'b0;
		dec1_wr = 1'b0;
		dec1_tgt = '0;
		cmp_valid = 1'b0;
		cmp_id = '0;
		br_miss = 1'b0;
		br_id = '0;
		m_valid = '1;
		m_tail = '0;
		foreach (m_src[i])
			m_src[i] = '0;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_eq("regfile_valid", m_valid, regfile_valid);
		check_eq("dec_ack", 1'b0, dec_ack);
		check_eq("commit0_valid", 1'b0, commit0_valid);
		check_eq("commit1_valid", 1'b0, commit1_valid);

		// Register 5 gets written three times, and slot 6 ends up as its producer
		decode(1'b1, 1'b1, 5'd5, 1'b1, 1'b1, 5'd7);
		decode(1'b1, 1'b1, 5'd0, 1'b1, 1'b0, 5'd9);
		decode(1'b0, 1'b0, 5'd0, 1'b1, 1'b1, 5'd12);
		decode(1'b1, 1'b1, 5'd5, 1'b1, 1'b1, 5'd5);
		complete_random(1);
		drain_to(1);
		complete_random(0);
		drain_to(0);

		// The older writer of register 3 survives the miss, the writers of 8 and 10 do not
		decode(1'b1, 1'b1, 5'd3, 1'b1, 1'b1, 5'd4);
		decode(1'b1, 1'b1, 5'd3, 1'b1, 1'b1, 5'd8);
		decode(1'b1, 1'b1, 5'd10, 1'b0, 1'b0, 5'd0);
		branch_miss(3'd0);
		complete_random(0);
		drain_to(0);

		// Fill every slot, then a request has to wait for two commits
		decode(1'b1, 1'b1, 5'd13, 1'b1, 1'b1, 5'd14);
		decode(1'b1, 1'b1, 5'd15, 1'b1, 1'b1, 5'd16);
		decode(1'b1, 1'b1, 5'd13, 1'b1, 1'b0, 5'd17);
		decode(1'b1, 1'b1, 5'd18, 1'b1, 1'b1, 5'd19);
		fork
			decode(1'b1, 1'b1, 5'd20, 1'b1, 1'b1, 5'd21);
			begin
				repeat (4) begin
					@(negedge clk);
					check_eq("dec_ack", 1'b0, dec_ack);
				end
				oldest = q_id[0];
				second = q_id[1];
				complete(oldest);
				complete(second);
			end
		join
		complete_random(0);
		drain_to(0);

		$display("Test passed");
		$finish;
	end

endmodule

//--- files.f
hdl/rob_pkg.sv
hdl/reorder_buffer.sv
hdl/reg_source_table.sv
hdl/regfile_valid.sv
hdl/scoreboard_top.sv
verification/tb_scoreboard_top.sv

//--- Bender.yml
package:
  name: rob_scoreboard

sources:
  # Synthesizable scoreboard, package first
  - files:
      - hdl/rob_pkg.sv
      - hdl/reorder_buffer.sv
      - hdl/reg_source_table.sv
      - hdl/regfile_valid.sv
      - hdl/scoreboard_top.sv

  # Simulation only
  - target: test
    files:
      - verification/tb_scoreboard_top.sv
